/* src/eth_mac_pkg.sv */
// Ethernet MAC package with stream and XGMII word types, FSM states and line constants
`default_nettype none

package eth_mac_pkg;

    // Frame FIFO geometry, pointers carry one extra wrap bit
    localparam int FIFO_DEPTH      = 256;
    localparam int FIFO_ADDR_WIDTH = 8;

    // XGMII control characters
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hFB;
    localparam logic [7:0] XGMII_TERM  = 8'hFD;

    // Preamble bytes 55 55 55 and SFD D5 that follow the start word, byte 0 lowest
    localparam logic [31:0] PREAMBLE_WORD = 32'hD555_5555;

    // Reflected CRC-32 as used for the Ethernet FCS
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

    // User side stream word
    typedef struct packed {
        logic [31:0] data;
        logic        last;
        logic        user;
    } axis_word_t;

    // Line side word, one control flag per byte lane
    typedef struct packed {
        logic [31:0] d;
        logic [3:0]  c;
    } xgmii_word_t;

    localparam xgmii_word_t XGMII_IDLE_WORD = '{d: {4{XGMII_IDLE}}, c: 4'hF};

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_DATA,
        TX_FCS,
        TX_TERM,
        TX_IFG
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_DATA
    } rx_state_t;

endpackage

`default_nettype wire

/* src/eth_crc32.sv */
// CRC-32 update over one 32-bit word, least significant byte and bit first
`timescale 1ns/1ps
`default_nettype none

module eth_crc32 import eth_mac_pkg::*; (
    input  logic [31:0] crc_in,
    input  logic [31:0] data,
    output logic [31:0] crc_out
);

    // Whole word folded in first, then 32 shift steps
    function automatic logic [31:0] crc_word(input logic [31:0] crc,
                                             input logic [31:0] word);
        logic [31:0] c;
        c = crc ^ word;
        for (int i = 0; i < 32; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_out = crc_word(crc_in, data);

endmodule

`default_nettype wire

/* src/eth_frame_fifo.sv */
// Store-and-forward frame FIFO that drops bad frames and frames that overflow it
`timescale 1ns/1ps
`default_nettype none

module eth_frame_fifo import eth_mac_pkg::*; (
    input  logic       logic_clk,
    input  logic       logic_rst,
    input  axis_word_t in,
    input  logic       in_valid,
    output logic       in_ready,
    output axis_word_t out,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       status_good_frame,
    output logic       status_bad_frame,
    output logic       status_overflow
);

    axis_word_t mem [FIFO_DEPTH];

    logic [FIFO_ADDR_WIDTH:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH:0] wr_commit;
    logic [FIFO_ADDR_WIDTH:0] rd_ptr;
    logic [FIFO_ADDR_WIDTH:0] commit_level;
    logic                     drop_frame;
    logic                     full;
    logic                     wr_take;
    logic                     wr_store;

    axis_word_t s1_word;
    logic       s1_valid;
    logic       s1_ready;
    logic       s2_ready;
    logic       rd_en;

    assign full = (wr_ptr == {~rd_ptr[FIFO_ADDR_WIDTH], rd_ptr[FIFO_ADDR_WIDTH-1:0]});
    assign wr_take = in_valid && in_ready;
    assign wr_store = wr_take && !drop_frame && !full;
    assign commit_level = wr_commit - rd_ptr;

    // Write side with commit and rewind
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            in_ready          <= 1'b0;
            wr_ptr            <= '0;
            wr_commit         <= '0;
            drop_frame        <= 1'b0;
            status_good_frame <= 1'b0;
            status_bad_frame  <= 1'b0;
            status_overflow   <= 1'b0;
        end else begin
            in_ready          <= 1'b1;
            status_good_frame <= 1'b0;
            status_bad_frame  <= 1'b0;
            status_overflow   <= 1'b0;
            if (wr_take) begin
                if (drop_frame) begin
                    // Swallow the rest of an overflowed frame
                    if (in.last) begin
                        drop_frame <= 1'b0;
                    end
                end else if (full) begin
                    wr_ptr          <= wr_commit;
                    drop_frame      <= !in.last;
                    status_overflow <= 1'b1;
                end else if (in.last && in.user) begin
                    wr_ptr           <= wr_commit;
                    status_bad_frame <= 1'b1;
                end else if (in.last) begin
                    wr_ptr            <= wr_ptr + 1'b1;
                    wr_commit         <= wr_ptr + 1'b1;
                    status_good_frame <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (wr_store) begin
            mem[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= in;
        end
    end

    // Two stage read pipeline, RAM register then output register
    assign s2_ready = !out_valid || out_ready;
    assign s1_ready = !s1_valid || s2_ready;
    assign rd_en = (rd_ptr != wr_commit) && s1_ready;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            rd_ptr    <= '0;
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr   <= rd_ptr + 1'b1;
                s1_valid <= 1'b1;
            end else if (s2_ready) begin
                s1_valid <= 1'b0;
            end
            if (s2_ready) begin
                out_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (rd_en) begin
            s1_word <= mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
        end
        if (s2_ready) begin
            out <= s1_word;
        end
    end

    // Reader only ever sees committed words
    a_rd_behind_commit: assert property (@(posedge logic_clk) disable iff (logic_rst)
        commit_level <= FIFO_DEPTH)
        else $error("read pointer passed the committed pointer");

    a_out_stable: assert property (@(posedge logic_clk) disable iff (logic_rst)
        out_valid && !out_ready |=> out_valid && $stable(out))
        else $error("output word changed under a stall");

endmodule

`default_nettype wire

/* src/eth_mac_tx.sv */
// Transmit MAC framing stream words onto XGMII with preamble, FCS, terminate and gap
`timescale 1ns/1ps
`default_nettype none

module eth_mac_tx import eth_mac_pkg::*; (
    input  logic        logic_clk,
    input  logic        logic_rst,
    input  axis_word_t  in,
    input  logic        in_valid,
    output logic        in_ready,
    output xgmii_word_t xgmii_tx,
    input  logic [7:0]  cfg_ifg,
    input  logic        cfg_tx_enable
);

    tx_state_t   state;
    logic [31:0] crc;
    logic [31:0] crc_next;
    logic [8:0]  ifg_sum;
    logic [6:0]  ifg_words;
    logic [6:0]  ifg_left;

    // Words are taken only while the payload is going out
    assign in_ready = (state == TX_DATA);

    // Gap in whole words, rounded up, never below one
    assign ifg_sum = {1'b0, cfg_ifg} + 9'd3;
    assign ifg_words = (ifg_sum[8:2] == 7'd0) ? 7'd1 : ifg_sum[8:2];

    eth_crc32 crc_inst (
        .crc_in  (crc),
        .data    (in.data),
        .crc_out (crc_next)
    );

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state    <= TX_IDLE;
            xgmii_tx <= XGMII_IDLE_WORD;
            crc      <= CRC_INIT;
            ifg_left <= '0;
        end else begin
            xgmii_tx <= XGMII_IDLE_WORD;
            case (state)
                TX_IDLE: begin
                    if (cfg_tx_enable && in_valid) begin
                        // Start character in lane 0, first preamble bytes above it
                        xgmii_tx <= '{d: {PREAMBLE_WORD[23:0], XGMII_START}, c: 4'h1};
                        state    <= TX_PREAMBLE;
                    end
                end
                TX_PREAMBLE: begin
                    xgmii_tx <= '{d: PREAMBLE_WORD, c: 4'h0};
                    crc      <= CRC_INIT;
                    state    <= TX_DATA;
                end
                TX_DATA: begin
                    // Frame is complete in the FIFO, so valid holds here
                    if (in_valid) begin
                        xgmii_tx <= '{d: in.data, c: 4'h0};
                        crc      <= crc_next;
                        if (in.last) begin
                            state <= TX_FCS;
                        end
                    end
                end
                TX_FCS: begin
                    xgmii_tx <= '{d: ~crc, c: 4'h0};
                    state    <= TX_TERM;
                end
                TX_TERM: begin
                    xgmii_tx <= '{d: {{3{XGMII_IDLE}}, XGMII_TERM}, c: 4'hF};
                    ifg_left <= ifg_words;
                    state    <= TX_IFG;
                end
                TX_IFG: begin
                    ifg_left <= ifg_left - 1'b1;
                    if (ifg_left == 7'd1) begin
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // Store-and-forward source never runs dry while the payload is going out
    a_ready_in_data: assert property (@(posedge logic_clk) disable iff (logic_rst)
        in_ready |-> in_valid)
        else $error("transmit FIFO ran empty in the middle of a frame");

endmodule

`default_nettype wire

/* src/eth_mac_rx.sv */
// Receive MAC decoding XGMII, checking and stripping the FCS and flagging bad frames
`timescale 1ns/1ps
`default_nettype none

module eth_mac_rx import eth_mac_pkg::*; (
    input  logic        logic_clk,
    input  logic        logic_rst,
    input  xgmii_word_t xgmii_rx,
    output axis_word_t  out,
    output logic        out_valid,
    input  logic        cfg_rx_enable,
    output logic        rx_error_bad_fcs
);

    rx_state_t   state;
    logic [31:0] hold_a;
    logic [31:0] hold_b;
    logic [31:0] crc;
    logic [31:0] crc_next;
    logic        a_valid;
    logic        b_valid;
    logic        frame_err;
    logic        is_ctrl;
    logic        is_start;
    logic        is_term;
    logic        in_data;
    logic        frame_end;
    logic        fcs_ok;
    logic        frame_bad;

    assign is_ctrl = |xgmii_rx.c;
    assign is_start = (xgmii_rx.c == 4'h1) && (xgmii_rx.d[7:0] == XGMII_START);
    assign is_term = xgmii_rx.c[0] && (xgmii_rx.d[7:0] == XGMII_TERM);
    assign in_data = (state == RX_DATA) && !is_ctrl;
    // Any control word ends the frame, only a terminate ends it cleanly
    assign frame_end = (state == RX_DATA) && is_ctrl;

    // hold_b is the FCS candidate, the CRC covers every word before it
    assign fcs_ok = (hold_b == ~crc);
    assign frame_bad = frame_err || !is_term || !fcs_ok;

    eth_crc32 crc_inst (
        .crc_in  (crc),
        .data    (hold_b),
        .crc_out (crc_next)
    );

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state            <= RX_IDLE;
            a_valid          <= 1'b0;
            b_valid          <= 1'b0;
            frame_err        <= 1'b0;
            out_valid        <= 1'b0;
            rx_error_bad_fcs <= 1'b0;
        end else begin
            out_valid        <= a_valid && (in_data || frame_end);
            rx_error_bad_fcs <= a_valid && frame_end && is_term && !fcs_ok;
            case (state)
                RX_IDLE: begin
                    if (cfg_rx_enable && is_start) begin
                        // Upper lanes of the start word hold the first preamble bytes
                        frame_err <= (xgmii_rx.d[31:8] != PREAMBLE_WORD[23:0]);
                        state     <= RX_PREAMBLE;
                    end
                end
                RX_PREAMBLE: begin
                    a_valid <= 1'b0;
                    b_valid <= 1'b0;
                    if (is_ctrl || (xgmii_rx.d != PREAMBLE_WORD)) begin
                        frame_err <= 1'b1;
                    end
                    state <= RX_DATA;
                end
                RX_DATA: begin
                    if (frame_end) begin
                        state <= RX_IDLE;
                    end else begin
                        b_valid <= 1'b1;
                        a_valid <= b_valid;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Two word hold back, so last goes out with the terminate
    always_ff @(posedge logic_clk) begin
        if (state == RX_PREAMBLE) begin
            crc <= CRC_INIT;
        end else if (in_data && b_valid) begin
            crc <= crc_next;
        end
        if (in_data) begin
            hold_b <= xgmii_rx.d;
            hold_a <= hold_b;
            out    <= '{data: hold_a, last: 1'b0, user: 1'b0};
        end else if (frame_end) begin
            out <= '{data: hold_a, last: 1'b1, user: frame_bad};
        end
    end

endmodule

`default_nettype wire

/* src/eth_mac_fifo.sv */
// Ethernet MAC top level with transmit and receive frame FIFOs
`timescale 1ns/1ps
`default_nettype none

module eth_mac_fifo import eth_mac_pkg::*; (
    input  logic        logic_clk,
    input  logic        logic_rst,
    input  axis_word_t  tx_in,
    input  logic        tx_valid,
    output logic        tx_ready,
    output axis_word_t  rx_out,
    output logic        rx_valid,
    input  logic        rx_ready,
    output xgmii_word_t xgmii_tx,
    input  xgmii_word_t xgmii_rx,
    input  logic [7:0]  cfg_ifg,
    input  logic        cfg_tx_enable,
    input  logic        cfg_rx_enable,
    output logic        rx_error_bad_fcs,
    output logic        tx_fifo_overflow,
    output logic        tx_fifo_bad_frame,
    output logic        tx_fifo_good_frame,
    output logic        rx_fifo_overflow,
    output logic        rx_fifo_bad_frame,
    output logic        rx_fifo_good_frame
);

    // FIFO to transmit MAC
    axis_word_t tx_mac_in;
    logic       tx_mac_valid;
    logic       tx_mac_ready;

    // Receive MAC to FIFO, no back-pressure
    axis_word_t rx_mac_out;
    logic       rx_mac_valid;

    eth_frame_fifo tx_fifo (
        .logic_clk         (logic_clk),
        .logic_rst         (logic_rst),
        .in                (tx_in),
        .in_valid          (tx_valid),
        .in_ready          (tx_ready),
        .out               (tx_mac_in),
        .out_valid         (tx_mac_valid),
        .out_ready         (tx_mac_ready),
        .status_good_frame (tx_fifo_good_frame),
        .status_bad_frame  (tx_fifo_bad_frame),
        .status_overflow   (tx_fifo_overflow)
    );

    eth_mac_tx mac_tx (
        .logic_clk     (logic_clk),
        .logic_rst     (logic_rst),
        .in            (tx_mac_in),
        .in_valid      (tx_mac_valid),
        .in_ready      (tx_mac_ready),
        .xgmii_tx      (xgmii_tx),
        .cfg_ifg       (cfg_ifg),
        .cfg_tx_enable (cfg_tx_enable)
    );

    eth_mac_rx mac_rx (
        .logic_clk        (logic_clk),
        .logic_rst        (logic_rst),
        .xgmii_rx         (xgmii_rx),
        .out              (rx_mac_out),
        .out_valid        (rx_mac_valid),
        .cfg_rx_enable    (cfg_rx_enable),
        .rx_error_bad_fcs (rx_error_bad_fcs)
    );

    eth_frame_fifo rx_fifo (
        .logic_clk         (logic_clk),
        .logic_rst         (logic_rst),
        .in                (rx_mac_out),
        .in_valid          (rx_mac_valid),
        .in_ready          (),
        .out               (rx_out),
        .out_valid         (rx_valid),
        .out_ready         (rx_ready),
        .status_good_frame (rx_fifo_good_frame),
        .status_bad_frame  (rx_fifo_bad_frame),
        .status_overflow   (rx_fifo_overflow)
    );

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
// Testbench clock source with a 4 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic logic_clk
);

    initial begin
        logic_clk = 1'b0;
        forever begin
            #2 logic_clk = ~logic_clk;
        end
    end

endmodule

`default_nettype wire

/* test/tb_eth_mac_fifo.sv */
// Table-driven XGMII loopback testbench for the Ethernet MAC with frame FIFOs
`timescale 1ns/1ps
`default_nettype none

module tb_eth_mac_fifo import eth_mac_pkg::*; ();

    localparam int NUM_ROWS    = 8;
    localparam int ROW_TIMEOUT = 5000;
    localparam logic [31:0] SEED = 32'h804325e8;
    localparam xgmii_word_t LINE_IDLE = '{d: {4{XGMII_IDLE}}, c: 4'hF};

    // Columns: test, length, data seed, tx user, corrupt, stall percent, ifg, tx enable, count
    typedef struct packed {
        logic [3:0]  test_id;
        logic [4:0]  len;
        logic [31:0] seed;
        logic        user;
        logic        corrupt;
        logic [6:0]  stall;
        logic [7:0]  ifg;
        logic        tx_en;
        logic [2:0]  count;
    } row_t;

    logic        logic_clk;
    logic        logic_rst;
    axis_word_t  tx_in;
    logic        tx_valid;
    logic        tx_ready;
    axis_word_t  rx_out;
    logic        rx_valid;
    logic        rx_ready;
    xgmii_word_t xgmii_tx;
    xgmii_word_t xgmii_rx;
    logic [7:0]  cfg_ifg;
    logic        cfg_tx_enable;
    logic        cfg_rx_enable;
    logic        rx_error_bad_fcs;
    logic        tx_fifo_overflow;
    logic        tx_fifo_bad_frame;
    logic        tx_fifo_good_frame;
    logic        rx_fifo_overflow;
    logic        rx_fifo_bad_frame;
    logic        rx_fifo_good_frame;
    logic [7:0]  events;

    row_t       rows [NUM_ROWS];
    axis_word_t exp_q [$];
    int         counts [8];
    int         errors;
    int         checks;
    int         stall_pct;
    int         line_pos;
    int         gap_cnt;
    int         gap_need;
    int         gap_checks;
    bit         in_gap;
    bit         corrupt_armed;

    tb_clock_gen clock_gen (.logic_clk(logic_clk));

    eth_mac_fifo dut (.*);

    // Event order matches event_name below, bit 7 is a start word on the line
    assign events = {(xgmii_tx.c == 4'h1) && (xgmii_tx.d[7:0] == XGMII_START),
                     rx_error_bad_fcs, rx_fifo_overflow, rx_fifo_bad_frame,
                     rx_fifo_good_frame, tx_fifo_overflow, tx_fifo_bad_frame,
                     tx_fifo_good_frame};

    function automatic string event_name(input int i);
        case (i)
            0: return "tx good frame";
            1: return "tx bad frame";
            2: return "tx overflow";
            3: return "rx good frame";
            4: return "rx bad frame";
            5: return "rx overflow";
            6: return "rx bad fcs";
            default: return "start word";
        endcase
    endfunction

    function automatic void report_mismatch(input string msg);
        errors++;
        $display("mismatch at %0t: %s", $time, msg);
    endfunction

    function automatic void print_counts();
        $display("%0d table rows, %0d checks, %0d errors", NUM_ROWS, checks, errors);
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        print_counts();
        $display("Test failures found");
        $finish;
    endtask

    // Line monitor and loopback, the word seen mid-cycle is what the receiver samples next
    always @(negedge logic_clk) begin
        xgmii_word_t w;
        w = xgmii_tx;
        for (int i = 0; i < 8; i++) begin
            if (events[i]) begin
                counts[i]++;
            end
        end
        if (events[7]) begin
            if (in_gap) begin
                gap_checks++;
                checks++;
                if (gap_cnt < gap_need) begin
                    report_mismatch($sformatf("gap of %0d idle words, need %0d",
                                              gap_cnt, gap_need));
                end
            end
            in_gap = 1'b0;
            line_pos = 0;
        end else if (line_pos < 64) begin
            line_pos++;
        end
        if (w.c == 4'hF && w.d[7:0] == XGMII_TERM) begin
            in_gap = 1'b1;
            gap_cnt = 0;
            gap_need = (int'(cfg_ifg) + 3) / 4;
            if (gap_need == 0) begin
                gap_need = 1;
            end
        end else if (in_gap && w == LINE_IDLE) begin
            gap_cnt++;
        end
        if (!cfg_tx_enable && w != LINE_IDLE) begin
            report_mismatch("xgmii_tx not idle while transmit is disabled");
        end
        // Flip one bit of the second data word
        if (corrupt_armed && line_pos == 3) begin
            w.d[8] = ~w.d[8];
            corrupt_armed = 1'b0;
        end
        xgmii_rx = w;
    end

    // Receive side scoreboard
    always @(negedge logic_clk) begin
        axis_word_t expected_word;
        if (rx_valid && rx_ready) begin
            checks++;
            if (exp_q.size() == 0) begin
                report_mismatch($sformatf("unexpected rx word %h", rx_out.data));
            end else begin
                expected_word = exp_q.pop_front();
                if (rx_out !== expected_word) begin
                    report_mismatch($sformatf("rx word %h last %b user %b, expected %h last %b",
                                              rx_out.data, rx_out.last, rx_out.user,
                                              expected_word.data, expected_word.last));
                end
            end
        end
    end

    // Consumer stalls, the only user of the random stream
    initial begin
        rx_ready = 1'b0;
        void'($urandom(SEED));
        forever begin
            @(posedge logic_clk);
            #1;
            rx_ready = ($urandom % 100) >= stall_pct;
        end
    end

    task automatic push_word(input axis_word_t w);
        int waited;
        tx_in = w;
        tx_valid = 1'b1;
        waited = 0;
        @(negedge logic_clk);
        while (!tx_ready && waited < ROW_TIMEOUT) begin
            @(negedge logic_clk);
            waited++;
        end
        if (!tx_ready) begin
            abort_run("tx_ready stayed low, a frame could not be written");
        end
        @(posedge logic_clk);
        #1;
    endtask

    task automatic run_row(input row_t row);
        int         base [8];
        int         exp_count [8];
        int         gaps_base;
        int         errs_base;
        int         waited;
        axis_word_t w;
        cfg_ifg = row.ifg;
        cfg_tx_enable = row.tx_en;
        stall_pct = row.stall;
        corrupt_armed = row.corrupt;
        for (int i = 0; i < 8; i++) begin
            base[i] = counts[i];
        end
        gaps_base = gap_checks;
        errs_base = errors;
        exp_count[0] = row.user ? 0 : row.count;
        exp_count[1] = row.user ? row.count : 0;
        exp_count[2] = 0;
        exp_count[3] = (row.user || row.corrupt) ? 0 : row.count;
        exp_count[4] = row.corrupt ? row.count : 0;
        exp_count[5] = 0;
        exp_count[6] = row.corrupt ? row.count : 0;
        exp_count[7] = row.user ? 0 : row.count;
        for (int f = 0; f < row.count; f++) begin
            for (int i = 0; i < row.len; i++) begin
                w.data = row.seed ^ (f << 20) ^ ((i + 1) * 32'h9E37_79B1);
                w.last = (i == row.len - 1);
                w.user = row.user && w.last;
                if (!row.user && !row.corrupt) begin
                    exp_q.push_back('{data: w.data, last: w.last, user: 1'b0});
                end
                push_word(w);
            end
        end
        tx_valid = 1'b0;
        if (!row.tx_en) begin
            repeat (40) @(posedge logic_clk);
            #1;
            checks++;
            if (counts[7] != base[7]) begin
                report_mismatch("frame started while transmit was disabled");
            end
            cfg_tx_enable = 1'b1;
        end
        waited = 0;
        while (waited < ROW_TIMEOUT && (counts[3] - base[3] < exp_count[3] ||
               counts[4] - base[4] < exp_count[4] || counts[1] - base[1] < exp_count[1] ||
               exp_q.size() != 0)) begin
            @(posedge logic_clk);
            #1;
            waited++;
        end
        if (waited >= ROW_TIMEOUT) begin
            abort_run($sformatf("test %0d timed out waiting for its frames", row.test_id));
        end
        // Quiet period so late or extra pulses are counted
        repeat (30) @(posedge logic_clk);
        #1;
        for (int i = 0; i < 8; i++) begin
            checks++;
            if (counts[i] - base[i] != exp_count[i]) begin
                report_mismatch($sformatf("%s count %0d, expected %0d", event_name(i),
                                          counts[i] - base[i], exp_count[i]));
            end
        end
        if (row.test_id == 6) begin
            checks++;
            if (gap_checks - gaps_base < row.count - 1) begin
                report_mismatch("too few inter-frame gaps seen on xgmii_tx");
            end
        end
        $display("test %0d, %0d frames of %0d words: %s", row.test_id, row.count, row.len,
                 (errors == errs_base) ? "pass" : "fail");
    endtask

    initial begin
        logic_rst = 1'b1;
        tx_in = '0;
        tx_valid = 1'b0;
        xgmii_rx = LINE_IDLE;
        cfg_ifg = 8'd12;
        cfg_tx_enable = 1'b1;
        cfg_rx_enable = 1'b1;
        stall_pct = 0;
        line_pos = 64;
        in_gap = 1'b0;
        corrupt_armed = 1'b0;
        errors = 0;
        checks = 0;
        gap_checks = 0;

        rows[0] = {4'd1, 5'd6,  32'h1000_0000, 1'b0, 1'b0, 7'd0,  8'd12, 1'b1, 3'd3};
        rows[1] = {4'd2, 5'd8,  32'h2000_0000, 1'b0, 1'b1, 7'd0,  8'd12, 1'b1, 3'd1};
        rows[2] = {4'd3, 5'd5,  32'h3000_0000, 1'b1, 1'b0, 7'd0,  8'd12, 1'b1, 3'd1};
        rows[3] = {4'd3, 5'd3,  32'h3800_0000, 1'b0, 1'b0, 7'd0,  8'd12, 1'b1, 3'd1};
        rows[4] = {4'd4, 5'd12, 32'h4000_0000, 1'b0, 1'b0, 7'd50, 8'd12, 1'b1, 3'd4};
        rows[5] = {4'd5, 5'd4,  32'h5000_0000, 1'b0, 1'b0, 7'd0,  8'd12, 1'b0, 3'd1};
        rows[6] = {4'd6, 5'd2,  32'h6000_0000, 1'b0, 1'b0, 7'd0,  8'd12, 1'b1, 3'd3};
        rows[7] = {4'd6, 5'd20, 32'h6800_0000, 1'b0, 1'b0, 7'd0,  8'd20, 1'b1, 3'd3};

        repeat (15) @(posedge logic_clk);
        @(negedge logic_clk);
        checks++;
        if (tx_ready !== 1'b0 || rx_valid !== 1'b0 || xgmii_tx !== LINE_IDLE) begin
            report_mismatch("outputs not quiet during reset");
        end
        @(posedge logic_clk);
        #1;
        logic_rst = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end

        print_counts();
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* eth_mac_fifo.f */
src/eth_mac_pkg.sv
src/eth_crc32.sv
src/eth_frame_fifo.sv
src/eth_mac_tx.sv
src/eth_mac_rx.sv
src/eth_mac_fifo.sv
test/tb_clock_gen.sv
test/tb_eth_mac_fifo.sv
